/* logic/exec_pkg.sv */
// execute stage package
// widths, unit numbers, alu opcodes and the issue and completion packets
package exec_pkg;

	localparam int xlen           = 32;
	localparam int issue_ways     = 2;
	localparam int complete_width = 2;
	localparam int n_units        = 3;
	localparam int mult_stages    = 3;

	typedef logic [5:0] rob_idx_t;
	typedef logic [5:0] pr_idx_t;

	typedef enum logic [1:0] {
		alu_0  = 2'd0,
		alu_1  = 2'd1,
		mult_0 = 2'd2
	} fu_sel_t;  // also bit position in unit_busy

	typedef enum logic [2:0] {
		op_add, op_sub, op_and, op_or, op_xor, op_sll, op_srl, op_slt
	} alu_op_t;

	// completion priority, highest first
	localparam fu_sel_t grant_order [n_units] = '{mult_0, alu_0, alu_1};

	typedef struct packed {
		logic            valid;
		fu_sel_t         fu_sel;
		alu_op_t         alu_op;
		rob_idx_t        rob_idx;
		pr_idx_t         pr_idx;
		logic [xlen-1:0] rs1_value;
		logic [xlen-1:0] rs2_value;
	} issue_packet_t;

	typedef struct packed {
		logic            valid;
		rob_idx_t        rob_idx;
		pr_idx_t         pr_idx;
		logic [xlen-1:0] value;
	} complete_packet_t;

endpackage

/* logic/fu_result_if.sv */
// function unit result slot to completion arbiter
// the slot holds its result until a cycle with grant high
interface fu_result_if;

	logic                      valid;
	exec_pkg::rob_idx_t        rob_idx;
	exec_pkg::pr_idx_t         pr_idx;
	logic [exec_pkg::xlen-1:0] value;
	logic                      grant;  // only high together with valid

	modport unit (
		output valid, rob_idx, pr_idx, value,
		input  grant
	);

	modport arbiter (
		input  valid, rob_idx, pr_idx, value,
		output grant
	);

endinterface

/* logic/issue_router.sv */
// issue router
// steers each issue way to the function unit named by its fu_sel
module issue_router import exec_pkg::*; (
	input  issue_packet_t [issue_ways-1:0] issue_in,
	output issue_packet_t [n_units-1:0]    unit_issue
);

	always_comb begin
		unit_issue = '0;  // unnamed units see an empty packet

		// later ways overwrite earlier ones, so way 1 wins a clash
		for (int i = 0; i < issue_ways; i++) begin
			if (issue_in[i].valid) begin
				case (issue_in[i].fu_sel)
					alu_0, alu_1, mult_0: begin
						unit_issue[issue_in[i].fu_sel] = issue_in[i];
					end
					default: ;  // unknown select is dropped
				endcase
			end
		end
	end

endmodule

/* logic/alu_unit.sv */
// single-cycle alu
// computes one operation per cycle into a one-entry result slot
module alu_unit import exec_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  issue_packet_t  issue,
	output logic           busy,
	fu_result_if.unit      result
);

	logic [xlen-1:0] alu_value;
	logic            signed_less;
	logic            load;

	logic            slot_valid;
	rob_idx_t        slot_rob_idx;
	pr_idx_t         slot_pr_idx;
	logic [xlen-1:0] slot_value;

	assign signed_less = $signed(issue.rs1_value) < $signed(issue.rs2_value);

	always_comb begin
		alu_value = '0;
		case (issue.alu_op)
			op_add: alu_value = issue.rs1_value + issue.rs2_value;
			op_sub: alu_value = issue.rs1_value - issue.rs2_value;
			op_and: alu_value = issue.rs1_value & issue.rs2_value;
			op_or:  alu_value = issue.rs1_value | issue.rs2_value;
			op_xor: alu_value = issue.rs1_value ^ issue.rs2_value;
			op_sll: alu_value = issue.rs1_value << issue.rs2_value[4:0];
			op_srl: alu_value = issue.rs1_value >> issue.rs2_value[4:0];
			op_slt: alu_value = {{(xlen-1){1'b0}}, signed_less};
		endcase
	end

	assign busy = slot_valid && !result.grant;  // held result blocks a new one
	assign load = issue.valid && !busy;

	always_ff @(posedge clock) begin
		if (reset) begin
			slot_valid <= 1'b0;
		end else if (load) begin
			slot_valid <= 1'b1;
		end else if (result.grant) begin
			slot_valid <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			slot_rob_idx <= issue.rob_idx;
			slot_pr_idx  <= issue.pr_idx;
			slot_value   <= alu_value;
		end
	end

	assign result.valid   = slot_valid;
	assign result.rob_idx = slot_rob_idx;
	assign result.pr_idx  = slot_pr_idx;
	assign result.value   = slot_value;

endmodule

/* logic/mult_unit.sv */
// pipelined multiplier
// low word of the unsigned product, mult_stages deep, last stage is the result slot
module mult_unit import exec_pkg::*; (
	input  logic           clock,
	input  logic           reset,
	input  issue_packet_t  issue,
	output logic           busy,
	fu_result_if.unit      result
);

	logic                   advance;
	logic [xlen-1:0]        product;

	logic [mult_stages-1:0] stage_valid;
	rob_idx_t               stage_rob_idx [mult_stages];
	pr_idx_t                stage_pr_idx  [mult_stages];
	logic [xlen-1:0]        stage_value   [mult_stages];

	assign product = issue.rs1_value * issue.rs2_value;  // low word only

	////////////////////////////////////////////////////////////////////////////
	// one enable for the whole pipe
	////////////////////////////////////////////////////////////////////////////

	assign advance = !stage_valid[mult_stages-1] || result.grant;
	assign busy    = !advance;  // a stalled pipe drops new issues

	always_ff @(posedge clock) begin
		if (reset) begin
			stage_valid <= '0;
		end else if (advance) begin
			stage_valid <= {stage_valid[mult_stages-2:0], issue.valid};
		end
	end

	always_ff @(posedge clock) begin
		if (advance) begin
			stage_rob_idx[0] <= issue.rob_idx;
			stage_pr_idx[0]  <= issue.pr_idx;
			stage_value[0]   <= product;
			for (int k = 1; k < mult_stages; k++) begin
				stage_rob_idx[k] <= stage_rob_idx[k-1];
				stage_pr_idx[k]  <= stage_pr_idx[k-1];
				stage_value[k]   <= stage_value[k-1];
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// result slot
	////////////////////////////////////////////////////////////////////////////

	assign result.valid   = stage_valid[mult_stages-1];
	assign result.rob_idx = stage_rob_idx[mult_stages-1];
	assign result.pr_idx  = stage_pr_idx[mult_stages-1];
	assign result.value   = stage_value[mult_stages-1];

endmodule

/* logic/completion_arbiter.sv */
// completion arbiter
// grants up to complete_width held results by fixed priority, oldest first out
module completion_arbiter import exec_pkg::*; (
	fu_result_if.arbiter                   slots [n_units],
	output complete_packet_t [complete_width-1:0] complete_out
);

	complete_packet_t   slot_pkt [n_units];
	logic [n_units-1:0] grant_vec;
	logic [1:0]         n_granted;
	complete_packet_t   first_pkt;
	complete_packet_t   second_pkt;
	logic               swap;

	for (genvar u = 0; u < n_units; u++) begin : g_slot
		assign slot_pkt[u] = '{
			valid:   slots[u].valid,
			rob_idx: slots[u].rob_idx,
			pr_idx:  slots[u].pr_idx,
			value:   slots[u].value
		};
		assign slots[u].grant = grant_vec[u];
	end

	////////////////////////////////////////////////////////////////////////////
	// fixed priority pick
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		grant_vec  = '0;
		n_granted  = '0;
		first_pkt  = '0;
		second_pkt = '0;

		for (int p = 0; p < n_units; p++) begin
			if (slot_pkt[grant_order[p]].valid && n_granted < 2'(complete_width)) begin
				grant_vec[grant_order[p]] = 1'b1;
				if (n_granted == 2'd0) begin
					first_pkt = slot_pkt[grant_order[p]];
				end else begin
					second_pkt = slot_pkt[grant_order[p]];
				end
				n_granted = n_granted + 2'd1;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// age sort
	////////////////////////////////////////////////////////////////////////////

	// plain unsigned compare, no wrap
	assign swap = second_pkt.valid && (second_pkt.rob_idx < first_pkt.rob_idx);

	always_comb begin
		if (swap) begin
			complete_out[0] = second_pkt;
			complete_out[1] = first_pkt;
		end else begin
			complete_out[0] = first_pkt;
			complete_out[1] = second_pkt;  // valid low when only one granted
		end
	end

endmodule

/* logic/exec_stage.sv */
// superscalar execute stage
// two alus and a pipelined multiplier behind one completion arbiter
module exec_stage import exec_pkg::*; (
	input  logic                                  clock,
	input  logic                                  reset,
	input  issue_packet_t    [issue_ways-1:0]     issue_in,
	output complete_packet_t [complete_width-1:0] complete_out,
	output logic             [n_units-1:0]        unit_busy
);

	issue_packet_t [n_units-1:0] unit_issue;

	fu_result_if unit_result [n_units] ();

	issue_router u_issue_router (
		.issue_in   (issue_in),
		.unit_issue (unit_issue)
	);

	alu_unit u_alu_0 (
		.clock  (clock),
		.reset  (reset),
		.issue  (unit_issue[alu_0]),
		.busy   (unit_busy[alu_0]),
		.result (unit_result[alu_0])
	);

	alu_unit u_alu_1 (
		.clock  (clock),
		.reset  (reset),
		.issue  (unit_issue[alu_1]),
		.busy   (unit_busy[alu_1]),
		.result (unit_result[alu_1])
	);

	mult_unit u_mult_0 (
		.clock  (clock),
		.reset  (reset),
		.issue  (unit_issue[mult_0]),
		.busy   (unit_busy[mult_0]),
		.result (unit_result[mult_0])
	);

	completion_arbiter u_completion_arbiter (
		.slots        (unit_result),
		.complete_out (complete_out)
	);

endmodule

/* testbench/exec_stage_tb.sv */
// execute stage testbench
// directed and random issue traffic checked against a reference model kept by rob_idx
module exec_stage_tb import exec_pkg::*; ();

	localparam int n_random    = 400;
	localparam int drain_limit = 60;

	logic                                  clock;
	logic                                  reset;
	issue_packet_t    [issue_ways-1:0]     issue_in;
	complete_packet_t [complete_width-1:0] complete_out;
	logic             [n_units-1:0]        unit_busy;

	logic [xlen-1:0] exp_value   [64];  // model, indexed by rob_idx
	pr_idx_t         exp_pr      [64];
	int              issue_cycle [64];
	int              done_cycle  [64];
	logic [63:0]     pending;

	logic [31:0] lcg_state;
	rob_idx_t    next_rob;
	string       test_name;
	int          cycle;
	int          errors;
	int          test_errors;
	int          order_errors;
	int          tests_passed;
	int          tests_failed;

	exec_stage DUT (
		.clock        (clock),
		.reset        (reset),
		.issue_in     (issue_in),
		.complete_out (complete_out),
		.unit_busy    (unit_busy)
	);

	initial clock = 1'b0;
	always #10 clock = ~clock;

	////////////////////////////////////////////////////////////////////////////
	// model and helpers
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] rand_word();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [xlen-1:0] model_value(fu_sel_t fu, alu_op_t op,
			logic [xlen-1:0] a, logic [xlen-1:0] b);
		logic [xlen-1:0] r;
		r = '0;
		if (fu == mult_0) begin
			r = a * b;  // low word
		end else begin
			case (op)
				op_add: r = a + b;
				op_sub: r = a - b;
				op_and: r = a & b;
				op_or:  r = a | b;
				op_xor: r = a ^ b;
				op_sll: r = a << b[4:0];
				op_srl: r = a >> b[4:0];
				op_slt: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default: r = '0;
			endcase
		end
		return r;
	endfunction

	task automatic note_error();
		errors++;
		test_errors++;
	endtask

	task automatic begin_test(input string name);
		test_name   = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		if (test_errors == 0) begin
			$display("test %s: passed", test_name);
			tests_passed++;
		end else begin
			$display("test %s: failed with %0d errors", test_name, test_errors);
			tests_failed++;
		end
	endtask

	// scoreboard and ordering check on every sampled cycle
	task automatic check_outputs();
		complete_packet_t pkt;
		for (int e = 0; e < complete_width; e++) begin
			pkt = complete_out[e];
			if (pkt.valid && !pending[pkt.rob_idx]) begin
				$display("%s: completion for rob_idx %0d that is not outstanding",
					test_name, pkt.rob_idx);
				note_error();
			end else if (pkt.valid) begin
				if (pkt.value !== exp_value[pkt.rob_idx]) begin
					$display("Error %s: rob_idx %0d value expected %h, got %h", test_name,
						pkt.rob_idx, exp_value[pkt.rob_idx], pkt.value);
					note_error();
				end
				if (pkt.pr_idx !== exp_pr[pkt.rob_idx]) begin
					$display("Error %s: rob_idx %0d pr_idx expected %0d, got %0d", test_name,
						pkt.rob_idx, exp_pr[pkt.rob_idx], pkt.pr_idx);
					note_error();
				end
				pending[pkt.rob_idx]    = 1'b0;
				done_cycle[pkt.rob_idx] = cycle;
			end
		end
		if (complete_out[1].valid && !complete_out[0].valid) begin
			$display("ordering: entry 1 valid while entry 0 is not, in test %s", test_name);
			errors++;
			order_errors++;
		end
		if (complete_out[0].valid && complete_out[1].valid &&
				!(complete_out[0].rob_idx < complete_out[1].rob_idx)) begin
			$display("ordering: entry 0 rob_idx %0d is not below entry 1 rob_idx %0d",
				complete_out[0].rob_idx, complete_out[1].rob_idx);
			errors++;
			order_errors++;
		end
	endtask

	task automatic next_cycle();
		@(negedge clock);
		cycle++;
		check_outputs();
		issue_in = '0;  // issues last one cycle
	endtask

	task automatic drive_issue(input int way, input fu_sel_t fu, input alu_op_t op,
			input logic [xlen-1:0] a, input logic [xlen-1:0] b, output rob_idx_t rob);
		rob = next_rob;
		issue_in[way].valid     = 1'b1;
		issue_in[way].fu_sel    = fu;
		issue_in[way].alu_op    = op;
		issue_in[way].rob_idx   = rob;
		issue_in[way].pr_idx    = pr_idx_t'(rand_word() >> 8);
		issue_in[way].rs1_value = a;
		issue_in[way].rs2_value = b;
		exp_value[rob]   = model_value(fu, op, a, b);
		exp_pr[rob]      = issue_in[way].pr_idx;
		issue_cycle[rob] = cycle;
		pending[rob]     = 1'b1;
		next_rob         = next_rob + 6'd1;
	endtask

	task automatic wait_done(input rob_idx_t rob, input int limit);
		int n;
		n = 0;
		while (pending[rob] && n < limit) begin
			next_cycle();
			n++;
		end
		if (pending[rob]) begin
			$display("%s: rob_idx %0d did not complete within %0d cycles", test_name, rob, limit);
			note_error();
		end
	endtask

	task automatic wait_idle(input int limit);
		int n;
		n = 0;
		while (pending != '0 && n < limit) begin
			next_cycle();
			n++;
		end
		if (pending != '0) begin
			$display("%s: %0d results still outstanding after %0d cycles", test_name,
				$countones(pending), limit);
			note_error();
		end
	endtask

	task automatic check_latency(input rob_idx_t rob, input int expected);
		if (!pending[rob] && done_cycle[rob] - issue_cycle[rob] != expected) begin
			$display("Error %s: rob_idx %0d latency expected %0d, got %0d", test_name, rob,
				expected, done_cycle[rob] - issue_cycle[rob]);
			note_error();
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		rob_idx_t          rob_m;
		rob_idx_t          rob_a;
		rob_idx_t          rob_b;
		rob_idx_t          rob_list [3];
		logic [31:0]       r;
		logic [n_units-1:0] used;
		int                unit;
		int                issued;
		int                guard;

		reset        = 1'b1;
		issue_in     = '0;
		pending      = '0;
		next_rob     = '0;
		lcg_state    = 32'h2724_5677;
		cycle        = 0;
		errors       = 0;
		test_errors  = 0;
		order_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_name    = "reset";
		repeat (4) @(negedge clock);
		reset = 1'b0;

		begin_test("reset");
		for (int i = 0; i < 2; i++) begin
			next_cycle();
			for (int e = 0; e < complete_width; e++) begin
				if (complete_out[e].valid !== 1'b0) begin
					$display("Error reset: entry %0d valid expected 0, got %b", e,
						complete_out[e].valid);
					note_error();
				end
			end
			if (unit_busy !== '0) begin
				$display("Error reset: unit_busy expected 000, got %b", unit_busy);
				note_error();
			end
		end
		end_test();

		begin_test("alu_ops");
		for (int u = 0; u < 2; u++) begin
			for (int o = 0; o < 8; o++) begin
				next_cycle();
				drive_issue(0, fu_sel_t'(u[1:0]), alu_op_t'(o[2:0]), rand_word(), rand_word(),
					rob_a);
				wait_done(rob_a, 5);
				check_latency(rob_a, 1);
			end
		end
		wait_idle(drain_limit);
		end_test();

		begin_test("mult_pipe");
		for (int i = 0; i < 3; i++) begin
			next_cycle();
			drive_issue(1, mult_0, op_add, rand_word(), rand_word(), rob_list[i]);
		end
		for (int i = 0; i < 3; i++) begin
			wait_done(rob_list[i], 10);
			check_latency(rob_list[i], mult_stages);
		end
		wait_idle(drain_limit);
		end_test();

		begin_test("backpressure");
		next_cycle();
		drive_issue(0, mult_0, op_add, rand_word(), rand_word(), rob_m);
		next_cycle();
		next_cycle();
		drive_issue(0, alu_0, op_add, rand_word(), rand_word(), rob_a);
		drive_issue(1, alu_1, op_xor, rand_word(), rand_word(), rob_b);
		next_cycle();  // all three slots full here
		if (pending[rob_m] || pending[rob_a] || !pending[rob_b]) begin
			$display("backpressure: mult and alu_0 should complete before alu_1");
			note_error();
		end
		if (unit_busy[alu_1] !== 1'b1) begin
			$display("Error backpressure: alu_1 busy expected 1, got %b", unit_busy[alu_1]);
			note_error();
		end
		wait_done(rob_b, 5);
		check_latency(rob_m, mult_stages);
		check_latency(rob_a, 1);
		check_latency(rob_b, 2);
		wait_idle(drain_limit);
		end_test();

		begin_test("random");
		issued = 0;
		guard  = 0;
		while (issued < n_random && guard < 20 * n_random) begin
			next_cycle();
			guard++;
			used = '0;
			for (int w = 0; w < issue_ways; w++) begin
				r    = rand_word();
				unit = int'(r[9:8]);  // 3 means no issue on this way
				if (unit < n_units && issued < n_random && !used[unit] && !unit_busy[unit] &&
						!pending[next_rob]) begin
					used[unit] = 1'b1;
					drive_issue(w, fu_sel_t'(r[9:8]), alu_op_t'(r[12:10]), rand_word(),
						rand_word(), rob_a);
					issued++;
				end
			end
		end
		if (issued < n_random) begin
			$display("random: only %0d of %0d issues made before the cycle limit", issued,
				n_random);
			note_error();
		end
		wait_idle(drain_limit);
		end_test();

		begin_test("ordering");
		test_errors = order_errors;
		end_test();

		$display("%0d tests passed, %0d failed, %0d errors", tests_passed, tests_failed,
			errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* src.f */
logic/exec_pkg.sv
logic/fu_result_if.sv
logic/issue_router.sv
logic/alu_unit.sv
logic/mult_unit.sv
logic/completion_arbiter.sv
logic/exec_stage.sv
testbench/exec_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build the execute stage testbench with verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --top-module exec_stage_tb -f src.f \
	--Mdir obj_dir -o exec_stage_tb
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/exec_stage_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with no errors" "$log"; then
	echo "PASS"
	exit 0
fi
echo "FAIL"
exit 1
